/* logic/timer_defs.svh */
`ifndef TIMER_DEFS_SVH
`define TIMER_DEFS_SVH

// counters and external inputs come in equal numbers
`define TMR_CNT_NUM 4

// apb data width, also the counter width
`define TMR_DW 32

// apb address width
`define TMR_AW 32

// fixed register byte offsets
`define TMR_OFS_CNT_EN   32'h0000_0000
`define TMR_OFS_CNT_CLR  32'h0000_0004
`define TMR_OFS_EDGE_CFG 32'h0000_0008
`define TMR_OFS_INT_STS  32'h0000_000C
`define TMR_OFS_INT_EN   32'h0000_0010

// per-counter banks, one word per counter
`define TMR_OFS_TARGET   32'h0000_0020
`define TMR_OFS_COUNT    32'h0000_0040
`define TMR_OFS_STRIDE   4

`endif

/* logic/timer_pkg.sv */
`include "timer_defs.svh"

package timer_pkg;

  // status and enable width: matches first, then edges
  localparam int INT_W = 2 * `TMR_CNT_NUM;

  // apb pins gathered into one bundle
  typedef struct packed {
    logic [`TMR_AW-1:0] paddr;
    logic [`TMR_DW-1:0] pwdata;
    logic               pwrite;
    logic               psel;
    logic               penable;
  } apb_req_t;

  // per-input edge selection
  typedef enum logic [1:0] {
    EDGE_NONE = 2'd0,
    EDGE_RISE = 2'd1,
    EDGE_FALL = 2'd2,
    EDGE_BOTH = 2'd3
  } edge_mode_e;

  typedef edge_mode_e [`TMR_CNT_NUM-1:0] edge_cfg_t;

  // one count (or target) word per counter
  typedef logic [`TMR_CNT_NUM-1:0][`TMR_DW-1:0] cnt_vec_t;

  // counter control, clr is a single-cycle pulse
  typedef struct packed {
    logic [`TMR_CNT_NUM-1:0] en;
    logic [`TMR_CNT_NUM-1:0] clr;
    cnt_vec_t                target;
  } cnt_cfg_t;

  // write strobes into the interrupt block
  typedef struct packed {
    logic             sts_clr_wr;
    logic             en_wr;
    logic [INT_W-1:0] data;
  } intr_wr_t;

  // readback from the interrupt block
  typedef struct packed {
    logic [INT_W-1:0] sts;
    logic [INT_W-1:0] en;
  } intr_rd_t;

  // one-cycle event pulses, one bit per counter or input
  typedef logic [`TMR_CNT_NUM-1:0] evt_vec_t;

endpackage

/* logic/apb_regs.sv */
`include "timer_defs.svh"

module apb_regs import timer_pkg::*; (
  input  logic              i_pclk,
  input  logic              i_prst_n,
  input  apb_req_t          i_apb,
  output logic [`TMR_DW-1:0] o_prdata,
  output cnt_cfg_t          o_cnt_cfg,
  output edge_cfg_t         o_edge_cfg,
  output intr_wr_t          o_intr_wr,
  input  intr_rd_t          i_intr_rd,
  input  cnt_vec_t          i_count
);

  // setup phase only, access phase is a don't-care
  logic setup;
  logic wr_en;
  logic rd_en;

  // fixed register hits
  logic hit_cnt_en;
  logic hit_cnt_clr;
  logic hit_edge_cfg;
  logic hit_int_sts;
  logic hit_int_en;

  logic [`TMR_CNT_NUM-1:0] cnt_en;
  logic [`TMR_CNT_NUM-1:0] cnt_clr;
  cnt_vec_t                target;
  edge_cfg_t               edge_cfg;
  logic [`TMR_DW-1:0]      rd_data;

  assign setup = i_apb.psel & ~i_apb.penable;
  assign wr_en = setup & i_apb.pwrite;
  assign rd_en = setup & ~i_apb.pwrite;

  assign hit_cnt_en   = (i_apb.paddr == `TMR_OFS_CNT_EN);
  assign hit_cnt_clr  = (i_apb.paddr == `TMR_OFS_CNT_CLR);
  assign hit_edge_cfg = (i_apb.paddr == `TMR_OFS_EDGE_CFG);
  assign hit_int_sts  = (i_apb.paddr == `TMR_OFS_INT_STS);
  assign hit_int_en   = (i_apb.paddr == `TMR_OFS_INT_EN);

  // config registers, written at the end of setup
  always_ff @(posedge i_pclk or negedge i_prst_n) begin
    if (!i_prst_n) begin
      cnt_en   <= '0;
      target   <= '0;
      edge_cfg <= {`TMR_CNT_NUM{EDGE_NONE}};
    end else if (wr_en) begin
      if (hit_cnt_en) begin
        cnt_en <= i_apb.pwdata[`TMR_CNT_NUM-1:0];
      end
      // 2 bits per input, input 0 in the low pair
      if (hit_edge_cfg) begin
        for (int i = 0; i < `TMR_CNT_NUM; i++) begin
          edge_cfg[i] <= edge_mode_e'(i_apb.pwdata[2*i +: 2]);
        end
      end
      for (int i = 0; i < `TMR_CNT_NUM; i++) begin
        if (i_apb.paddr == `TMR_OFS_TARGET + 32'(`TMR_OFS_STRIDE * i)) begin
          target[i] <= i_apb.pwdata;
        end
      end
    end
  end

  // clear pulse lasts the cycle after setup, then drops
  always_ff @(posedge i_pclk or negedge i_prst_n) begin
    if (!i_prst_n) begin
      cnt_clr <= '0;
    end else if (wr_en && hit_cnt_clr) begin
      cnt_clr <= i_apb.pwdata[`TMR_CNT_NUM-1:0];
    end else begin
      cnt_clr <= '0;
    end
  end

  assign o_cnt_cfg.en     = cnt_en;
  assign o_cnt_cfg.clr    = cnt_clr;
  assign o_cnt_cfg.target = target;
  assign o_edge_cfg       = edge_cfg;

  // status and enable live in intr_ctrl, only strobes go there
  assign o_intr_wr.sts_clr_wr = wr_en & hit_int_sts;
  assign o_intr_wr.en_wr      = wr_en & hit_int_en;
  assign o_intr_wr.data       = i_apb.pwdata[INT_W-1:0];

  // read mux, anything unmapped stays 0
  always_comb begin
    case (i_apb.paddr)
      `TMR_OFS_CNT_EN:   rd_data = `TMR_DW'(cnt_en);
      `TMR_OFS_EDGE_CFG: rd_data = `TMR_DW'(edge_cfg);
      `TMR_OFS_INT_STS:  rd_data = `TMR_DW'(i_intr_rd.sts);
      `TMR_OFS_INT_EN:   rd_data = `TMR_DW'(i_intr_rd.en);
      // CNT_CLR is write-only
      default:           rd_data = '0;
    endcase
    for (int i = 0; i < `TMR_CNT_NUM; i++) begin
      if (i_apb.paddr == `TMR_OFS_TARGET + 32'(`TMR_OFS_STRIDE * i)) begin
        rd_data = target[i];
      end
      if (i_apb.paddr == `TMR_OFS_COUNT + 32'(`TMR_OFS_STRIDE * i)) begin
        rd_data = i_count[i];
      end
    end
  end

  // sampled in setup, held through access and until the next read
  always_ff @(posedge i_pclk or negedge i_prst_n) begin
    if (!i_prst_n) begin
      o_prdata <= '0;
    end else if (rd_en) begin
      o_prdata <= rd_data;
    end
  end

endmodule

/* logic/cnt_array.sv */
`include "timer_defs.svh"

module cnt_array import timer_pkg::*; (
  input  logic     i_pclk,
  input  logic     i_prst_n,
  input  cnt_cfg_t i_cfg,
  output cnt_vec_t o_count,
  output evt_vec_t o_match
);

  cnt_vec_t count;

  // wrap condition per counter
  logic [`TMR_CNT_NUM-1:0] at_target;

  genvar i;
  generate
    for (i = 0; i < `TMR_CNT_NUM; i++) begin : g_cnt

      // only an exact hit wraps
      // a target lowered below the count lets it run to 2^32
      assign at_target[i] = (count[i] == i_cfg.target[i]);

      always_ff @(posedge i_pclk or negedge i_prst_n) begin
        if (!i_prst_n) begin
          count[i] <= '0;
        end else if (i_cfg.clr[i]) begin
          // clear wins over enable and wrap
          count[i] <= '0;
        end else if (i_cfg.en[i]) begin
          if (at_target[i]) begin
            count[i] <= '0;
          end else begin
            count[i] <= count[i] + 1'b1;
          end
        end
        // disabled: hold
      end

      // match is high in the cycle the count sits on target
      // a clear in that cycle suppresses the wrap, so no event
      assign o_match[i] = i_cfg.en[i] & ~i_cfg.clr[i] & at_target[i];

    end
  endgenerate

  assign o_count = count;

endmodule

/* logic/ext_edge_det.sv */
`include "timer_defs.svh"

module ext_edge_det import timer_pkg::*; (
  input  logic                    i_pclk,
  input  logic                    i_prst_n,
  input  logic [`TMR_CNT_NUM-1:0] i_din,
  input  edge_cfg_t               i_mode,
  output evt_vec_t                o_edge
);

  // two flops against metastability, third for the previous value
  logic [`TMR_CNT_NUM-1:0] sync_q1;
  logic [`TMR_CNT_NUM-1:0] sync_q2;
  logic [`TMR_CNT_NUM-1:0] dly_q;

  logic [`TMR_CNT_NUM-1:0] rise;
  logic [`TMR_CNT_NUM-1:0] fall;
  logic [`TMR_CNT_NUM-1:0] edge_sel;

  always_ff @(posedge i_pclk or negedge i_prst_n) begin
    if (!i_prst_n) begin
      sync_q1 <= '0;
      sync_q2 <= '0;
      dly_q   <= '0;
    end else begin
      sync_q1 <= i_din;
      sync_q2 <= sync_q1;
      dly_q   <= sync_q2;
    end
  end

  assign rise = sync_q2 & ~dly_q;
  assign fall = ~sync_q2 & dly_q;

  // per-input mode picks which transitions count
  always_comb begin
    for (int i = 0; i < `TMR_CNT_NUM; i++) begin
      case (i_mode[i])
        EDGE_RISE: edge_sel[i] = rise[i];
        EDGE_FALL: edge_sel[i] = fall[i];
        EDGE_BOTH: edge_sel[i] = rise[i] | fall[i];
        default:   edge_sel[i] = 1'b0;
      endcase
    end
  end

  // registered pulse, third edge after the pin moves
  always_ff @(posedge i_pclk or negedge i_prst_n) begin
    if (!i_prst_n) begin
      o_edge <= '0;
    end else begin
      o_edge <= edge_sel;
    end
  end

endmodule

/* logic/intr_ctrl.sv */
`include "timer_defs.svh"

module intr_ctrl import timer_pkg::*; (
  input  logic     i_pclk,
  input  logic     i_prst_n,
  input  evt_vec_t i_match,
  input  evt_vec_t i_edge,
  input  intr_wr_t i_wr,
  output intr_rd_t o_rd,
  output logic     o_int
);

  // bits 3:0 counter matches, 7:4 input edges
  logic [INT_W-1:0] evt;
  logic [INT_W-1:0] clr_mask;
  logic [INT_W-1:0] sts;
  logic [INT_W-1:0] en;

  assign evt      = {i_edge, i_match};
  assign clr_mask = i_wr.sts_clr_wr ? i_wr.data : '0;

  // sticky status, w1c, a new event beats the clear
  always_ff @(posedge i_pclk or negedge i_prst_n) begin
    if (!i_prst_n) begin
      sts <= '0;
    end else begin
      sts <= (sts & ~clr_mask) | evt;
    end
  end

  // enable only gates the output, status still records
  always_ff @(posedge i_pclk or negedge i_prst_n) begin
    if (!i_prst_n) begin
      en <= '0;
    end else if (i_wr.en_wr) begin
      en <= i_wr.data;
    end
  end

  // level interrupt, one cycle behind status
  always_ff @(posedge i_pclk or negedge i_prst_n) begin
    if (!i_prst_n) begin
      o_int <= 1'b0;
    end else begin
      o_int <= |(sts & en);
    end
  end

  assign o_rd.sts = sts;
  assign o_rd.en  = en;

endmodule

/* logic/timer_top.sv */
`include "timer_defs.svh"

module timer_top import timer_pkg::*; (
  input  logic                    i_pclk,
  input  logic                    i_prst_n,
  // apb slave
  input  logic [`TMR_AW-1:0]      i_paddr,
  input  logic [`TMR_DW-1:0]      i_pwdata,
  input  logic                    i_pwrite,
  input  logic                    i_psel,
  input  logic                    i_penable,
  output logic [`TMR_DW-1:0]      o_prdata,
  // external event pins, asynchronous
  input  logic [`TMR_CNT_NUM-1:0] i_ext_din,
  output logic                    o_int
);

  apb_req_t  apb;
  cnt_cfg_t  cnt_cfg;
  edge_cfg_t edge_cfg;
  intr_wr_t  intr_wr;
  intr_rd_t  intr_rd;
  cnt_vec_t  count;
  evt_vec_t  match_evt;
  evt_vec_t  edge_evt;

  assign apb.paddr   = i_paddr;
  assign apb.pwdata  = i_pwdata;
  assign apb.pwrite  = i_pwrite;
  assign apb.psel    = i_psel;
  assign apb.penable = i_penable;

  // register file
  apb_regs apb_regs_inst (
    .i_pclk     (i_pclk),
    .i_prst_n   (i_prst_n),
    .i_apb      (apb),
    .o_prdata   (o_prdata),
    .o_cnt_cfg  (cnt_cfg),
    .o_edge_cfg (edge_cfg),
    .o_intr_wr  (intr_wr),
    .i_intr_rd  (intr_rd),
    .i_count    (count)
  );

  // counters and edge detect run side by side
  cnt_array cnt_array_inst (
    .i_pclk   (i_pclk),
    .i_prst_n (i_prst_n),
    .i_cfg    (cnt_cfg),
    .o_count  (count),
    .o_match  (match_evt)
  );

  ext_edge_det ext_edge_det_inst (
    .i_pclk   (i_pclk),
    .i_prst_n (i_prst_n),
    .i_din    (i_ext_din),
    .i_mode   (edge_cfg),
    .o_edge   (edge_evt)
  );

  // both event sources merge here
  intr_ctrl intr_ctrl_inst (
    .i_pclk   (i_pclk),
    .i_prst_n (i_prst_n),
    .i_match  (match_evt),
    .i_edge   (edge_evt),
    .i_wr     (intr_wr),
    .o_rd     (intr_rd),
    .o_int    (o_int)
  );

endmodule

/* sim/timer_assert.sv */
`include "timer_defs.svh"

module timer_assert import timer_pkg::*; (
  input logic               i_pclk,
  input logic               i_prst_n,
  input logic [`TMR_DW-1:0] i_prdata,
  input intr_rd_t           i_intr_rd,
  input logic               i_int
);
  timeunit 1ns;
  timeprecision 100ps;

  // async reset forces the interrupt flop low
  a_int_low_in_reset: assert property (
    @(posedge i_pclk) !i_prst_n |-> !i_int
  ) else $error("o_int high while reset is asserted");

  // read data flop always holds a known value
  a_prdata_known: assert property (
    @(posedge i_pclk) disable iff (!i_prst_n) !$isunknown(i_prdata)
  ) else $error("o_prdata unknown after reset");

  // o_int is one cycle behind the enabled status
  a_int_has_cause: assert property (
    @(posedge i_pclk) disable iff (!i_prst_n)
      i_int |-> $past(|(i_intr_rd.sts & i_intr_rd.en))
  ) else $error("o_int high without enabled status the cycle before");

endmodule

bind timer_top timer_assert timer_assert_inst (
  .i_pclk    (i_pclk),
  .i_prst_n  (i_prst_n),
  .i_prdata  (o_prdata),
  .i_intr_rd (intr_rd),
  .i_int     (o_int)
);

/* sim/timer_tb.sv */
`include "timer_defs.svh"

module timer_tb;
  timeunit 1ns;
  timeprecision 100ps;

  // limit sits well above the length of all tests together
  localparam int TIMEOUT_CYCLES = 3000;

  logic                    pclk;
  logic                    prst_n;
  logic [`TMR_AW-1:0]      paddr;
  logic [`TMR_DW-1:0]      pwdata;
  logic                    pwrite;
  logic                    psel;
  logic                    penable;
  logic [`TMR_DW-1:0]      prdata;
  logic [`TMR_CNT_NUM-1:0] ext_din;
  logic                    irq;

  int checks = 0;
  int errors = 0;
  int cycles = 0;

  timer_top timer_top_inst (
    .i_pclk    (pclk),
    .i_prst_n  (prst_n),
    .i_paddr   (paddr),
    .i_pwdata  (pwdata),
    .i_pwrite  (pwrite),
    .i_psel    (psel),
    .i_penable (penable),
    .o_prdata  (prdata),
    .i_ext_din (ext_din),
    .o_int     (irq)
  );

  // 20 ns clock
  initial begin
    pclk = 1'b0;
    forever #10 pclk = ~pclk;
  end

  // watchdog on the cycle count
  initial begin
    while (cycles < TIMEOUT_CYCLES) begin
      @(posedge pclk);
      cycles++;
    end
    $display("timeout: run still going after %0d cycles", cycles);
    $display("TESTBENCH FAILED");
    $finish;
  end

  // word address inside a per-counter bank
  function automatic logic [31:0] bank_addr(input logic [31:0] base, input int idx);
    return base + 32'(idx * `TMR_OFS_STRIDE);
  endfunction

  // setup cycle then access cycle with no wait states
  task automatic apb_write(input logic [31:0] addr, input logic [31:0] data);
    @(posedge pclk);
    #2;
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = 1'b1;
    paddr   = addr;
    pwdata  = data;
    @(posedge pclk);
    #2;
    penable = 1'b1;
    @(posedge pclk);
    #2;
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
  endtask

  // prdata is registered at the setup edge and taken in access
  task automatic apb_read(input logic [31:0] addr, output logic [31:0] data);
    @(posedge pclk);
    #2;
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = 1'b0;
    paddr   = addr;
    @(posedge pclk);
    #2;
    penable = 1'b1;
    data    = prdata;
    @(posedge pclk);
    #2;
    psel    = 1'b0;
    penable = 1'b0;
  endtask

  task automatic check_eq(input string name, input logic [31:0] exp, input logic [31:0] got);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("[FAIL] %0t %s expected %h got %h", $time, name, exp, got);
    end
  endtask

  task automatic read_check(input logic [31:0] addr, input logic [31:0] exp, input string name);
    logic [31:0] val;
    apb_read(addr, val);
    check_eq(name, exp, val);
  endtask

  // poll o_int once per cycle just after the edge
  task automatic wait_irq(input logic level, input int max_cycles, input string what);
    int n;
    n = 0;
    while (irq !== level && n < max_cycles) begin
      @(posedge pclk);
      #1;
      n++;
    end
    checks++;
    if (irq !== level) begin
      errors++;
      $display("o_int never went to %0b within %0d cycles at %0t (%s)",
               level, max_cycles, $time, what);
    end
  endtask

  // pin change needs 3 edges through sync and detect
  // status read then lands on the 5th edge
  task automatic edge_step(input int pin, input logic level, output logic [31:0] sts);
    @(posedge pclk);
    #2;
    ext_din[pin] = level;
    repeat (3) @(posedge pclk);
    apb_read(`TMR_OFS_INT_STS, sts);
  endtask

  task automatic finish_test(input string name, input int err0);
    $display("test %s done, %0d errors", name, errors - err0);
  endtask

  task automatic reset_readback();
    int          err0;
    logic [31:0] val;
    err0 = errors;
    read_check(`TMR_OFS_CNT_EN, 0, "CNT_EN");
    read_check(`TMR_OFS_EDGE_CFG, 0, "EDGE_CFG");
    read_check(`TMR_OFS_INT_STS, 0, "INT_STS");
    read_check(`TMR_OFS_INT_EN, 0, "INT_EN");
    for (int i = 0; i < `TMR_CNT_NUM; i++) begin
      read_check(bank_addr(`TMR_OFS_TARGET, i), 0, $sformatf("TARGET%0d", i));
      read_check(bank_addr(`TMR_OFS_COUNT, i), 0, $sformatf("COUNT%0d", i));
    end
    // full 32-bit targets
    for (int i = 0; i < `TMR_CNT_NUM; i++) begin
      val = $urandom;
      apb_write(bank_addr(`TMR_OFS_TARGET, i), val);
      read_check(bank_addr(`TMR_OFS_TARGET, i), val, $sformatf("TARGET%0d", i));
    end
    // 2 bits per input
    val = $urandom;
    apb_write(`TMR_OFS_EDGE_CFG, val);
    read_check(`TMR_OFS_EDGE_CFG, val & 32'hFF, "EDGE_CFG");
    // 8 enable bits
    val = $urandom;
    apb_write(`TMR_OFS_INT_EN, val);
    read_check(`TMR_OFS_INT_EN, val & 32'hFF, "INT_EN");
    read_check(`TMR_OFS_CNT_CLR, 0, "CNT_CLR");
    read_check(32'h0000_0080, 0, "unmapped");
    apb_write(`TMR_OFS_EDGE_CFG, 0);
    apb_write(`TMR_OFS_INT_EN, 0);
    finish_test("reset_readback", err0);
  endtask

  task automatic count_clear();
    int          err0;
    int          t;
    int          moves;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] prev;
    err0 = errors;
    moves = 0;
    prev = '0;
    t = 10 + ($urandom % 31);
    apb_write(bank_addr(`TMR_OFS_TARGET, 0), t);
    apb_write(`TMR_OFS_CNT_EN, 32'h1);
    // reads span several wraps
    for (int n = 0; n < 20; n++) begin
      apb_read(bank_addr(`TMR_OFS_COUNT, 0), a);
      checks++;
      if (a > t) begin
        errors++;
        $display("[FAIL] %0t COUNT0 expected <= %0d got %0d", $time, t, a);
      end
      // an enabled counter must show new values between reads
      if (n > 0 && a != prev) begin
        moves++;
      end
      prev = a;
    end
    checks++;
    if (moves == 0) begin
      errors++;
      $display("COUNT0 stayed at %0d over 20 reads while enabled, at %0t", prev, $time);
    end
    apb_write(`TMR_OFS_CNT_EN, 0);
    apb_read(bank_addr(`TMR_OFS_COUNT, 0), a);
    apb_read(bank_addr(`TMR_OFS_COUNT, 0), b);
    check_eq("COUNT0 held", a, b);
    apb_write(`TMR_OFS_CNT_CLR, 32'h1);
    read_check(bank_addr(`TMR_OFS_COUNT, 0), 0, "COUNT0 after clear");
    apb_write(`TMR_OFS_INT_STS, 32'hFF);
    finish_test("count_clear", err0);
  endtask

  task automatic match_irq();
    int          err0;
    int          idx;
    int          t;
    logic [31:0] sts;
    err0 = errors;
    idx = $urandom % `TMR_CNT_NUM;
    t = 3 + ($urandom % 6);
    apb_write(bank_addr(`TMR_OFS_TARGET, idx), t);
    apb_write(`TMR_OFS_CNT_CLR, 32'h1 << idx);
    apb_write(`TMR_OFS_INT_EN, 32'h1 << idx);
    apb_write(`TMR_OFS_CNT_EN, 32'h1 << idx);
    wait_irq(1'b1, t + 4, "counter match");
    apb_read(`TMR_OFS_INT_STS, sts);
    check_eq("INT_STS match bit", 1, 32'(sts[idx]));
    // stop new matches before the w1c
    apb_write(`TMR_OFS_CNT_EN, 0);
    apb_write(`TMR_OFS_INT_STS, 32'h1 << idx);
    wait_irq(1'b0, 2, "match status cleared");
    read_check(`TMR_OFS_INT_STS, 0, "INT_STS after clear");
    apb_write(`TMR_OFS_INT_EN, 0);
    finish_test("match_irq", err0);
  endtask

  task automatic ext_edges();
    int          err0;
    logic [31:0] sts;
    err0 = errors;
    // input 1 rise
    apb_write(`TMR_OFS_EDGE_CFG, 32'h4);
    edge_step(1, 1'b1, sts);
    check_eq("INT_STS rise, rise mode", 32'h20, sts);
    apb_write(`TMR_OFS_INT_STS, 32'hFF);
    edge_step(1, 1'b0, sts);
    check_eq("INT_STS fall, rise mode", 0, sts);
    // input 1 both
    apb_write(`TMR_OFS_EDGE_CFG, 32'hC);
    edge_step(1, 1'b1, sts);
    check_eq("INT_STS rise, both mode", 32'h20, sts);
    apb_write(`TMR_OFS_INT_STS, 32'hFF);
    edge_step(1, 1'b0, sts);
    check_eq("INT_STS fall, both mode", 32'h20, sts);
    apb_write(`TMR_OFS_INT_STS, 32'hFF);
    // none mode ignores both directions
    apb_write(`TMR_OFS_EDGE_CFG, 0);
    edge_step(1, 1'b1, sts);
    check_eq("INT_STS rise, none mode", 0, sts);
    edge_step(1, 1'b0, sts);
    check_eq("INT_STS fall, none mode", 0, sts);
    finish_test("ext_edges", err0);
  endtask

  task automatic masking();
    int          err0;
    logic [31:0] sts;
    err0 = errors;
    apb_write(`TMR_OFS_INT_EN, 0);
    apb_write(`TMR_OFS_INT_STS, 32'hFF);
    // input 2 rise
    apb_write(`TMR_OFS_EDGE_CFG, 32'h10);
    edge_step(2, 1'b1, sts);
    check_eq("INT_STS masked edge", 32'h40, sts);
    check_eq("o_int masked", 0, 32'(irq));
    apb_write(`TMR_OFS_INT_EN, 32'h40);
    wait_irq(1'b1, 2, "enable after masked edge");
    apb_write(`TMR_OFS_INT_STS, 32'h40);
    wait_irq(1'b0, 2, "edge status cleared");
    apb_write(`TMR_OFS_INT_EN, 0);
    apb_write(`TMR_OFS_EDGE_CFG, 0);
    finish_test("masking", err0);
  endtask

  initial begin
    void'($urandom(32'h6f35));
    prst_n  = 1'b0;
    paddr   = '0;
    pwdata  = '0;
    pwrite  = 1'b0;
    psel    = 1'b0;
    penable = 1'b0;
    ext_din = '0;
    repeat (3) @(posedge pclk);
    #2;
    prst_n = 1'b1;
    reset_readback();
    count_clear();
    match_irq();
    ext_edges();
    masking();
    $display("summary: %0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

/* build.f */
+incdir+logic
logic/timer_pkg.sv
logic/apb_regs.sv
logic/cnt_array.sv
logic/ext_edge_det.sv
logic/intr_ctrl.sv
logic/timer_top.sv
sim/timer_assert.sv
sim/timer_tb.sv

/* Makefile */
.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert --timescale 1ns/100ps \
		--top-module timer_tb -f build.f

sim:
	verilator --binary --assert --timescale 1ns/100ps \
		--top-module timer_tb -f build.f -o timer_sim
	./obj_dir/timer_sim | tee sim.log
	grep -q "TESTBENCH PASSED" sim.log

clean:
	rm -rf obj_dir sim.log
